//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int data_width = 32;
    localparam logic [data_width-1:0] reset_vector = 32'h0040_0000;

    typedef logic [4:0] reg_addr_t;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // funct codes under op_special
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_lui
    } alu_op_t;

    typedef enum logic {
        wb_alu,
        wb_mem
    } wb_sel_t;

    typedef struct packed {
        logic [data_width-1:0] instr;
        // pc plus 4 of the fetched word, base of branch targets
        logic [data_width-1:0] npc;
    } if_id_t;

    typedef struct packed {
        logic [data_width-1:0] op_a;
        logic [data_width-1:0] op_b;
        logic [data_width-1:0] store_data;
        alu_op_t               alu_op;
        reg_addr_t             dest;
        logic                  reg_we;
        logic                  mem_we;
        logic                  mem_rd;
        wb_sel_t               wb_sel;
    } id_ex_t;

    typedef struct packed {
        logic [data_width-1:0] result;
        logic [data_width-1:0] store_data;
        reg_addr_t             dest;
        logic                  reg_we;
        logic                  mem_we;
        logic                  mem_rd;
        wb_sel_t               wb_sel;
    } ex_mem_t;

    typedef struct packed {
        logic [data_width-1:0] result;
        reg_addr_t             dest;
        logic                  reg_we;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- source/fetch_unit.sv
`default_nettype none

module fetch_unit #(
    parameter int                    DATA_WIDTH = cpu_pkg::data_width,
    parameter logic [DATA_WIDTH-1:0] RESET_PC   = cpu_pkg::reset_vector
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  halt,
    input  logic                  stall_load,
    input  logic                  branch_taken,
    input  logic [DATA_WIDTH-1:0] branch_target,
    output logic [DATA_WIDTH-1:0] imem_addr,
    output logic [DATA_WIDTH-1:0] pc_plus4
);

    logic [DATA_WIDTH-1:0] pc;
    logic [DATA_WIDTH-1:0] next_pc;

    assign pc_plus4 = pc + DATA_WIDTH'(4);

    // taken branch or jump wins over sequential fetch
    always_comb
    begin
        if (branch_taken)
            next_pc = branch_target;
        else
            next_pc = pc_plus4;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pc <= RESET_PC;
        end
        else if (!(halt || stall_load))
        begin
            pc <= next_pc;
        end
    end

    assign imem_addr = pc;

endmodule

`default_nettype wire

//--- source/pipe_stage.sv
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // an all-zero payload decodes as a no-op
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            q <= '0;
        else if (!hold)
        begin
            if (bubble)
                q <= '0;
            else
                q <= d;
        end
    end

endmodule

`default_nettype wire

//--- source/reg_file.sv
`default_nettype none

module reg_file #(
    parameter int DATA_WIDTH = cpu_pkg::data_width
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we,
    input  cpu_pkg::reg_addr_t    waddr,
    input  cpu_pkg::reg_addr_t    raddr_a,
    input  cpu_pkg::reg_addr_t    raddr_b,
    input  logic [DATA_WIDTH-1:0] wdata,
    output logic [DATA_WIDTH-1:0] rdata_a,
    output logic [DATA_WIDTH-1:0] rdata_b,
    output logic [DATA_WIDTH-1:0] probe
);

    logic [DATA_WIDTH-1:0] regs [32];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            regs <= '{default: '0};
        else if (we && waddr != '0)
            regs[waddr] <= wdata;
    end

    // r0 never written, so it stays zero
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];
    assign probe   = regs[28];

endmodule

`default_nettype wire

//--- source/decode_unit.sv
`default_nettype none

module decode_unit #(
    parameter int DATA_WIDTH = cpu_pkg::data_width
) (
    input  cpu_pkg::if_id_t       if_id,
    input  cpu_pkg::id_ex_t       id_ex_q,
    input  logic [DATA_WIDTH-1:0] ex_result,
    input  cpu_pkg::ex_mem_t      ex_mem_q,
    input  logic [DATA_WIDTH-1:0] wb_data,
    input  cpu_pkg::reg_addr_t    wb_addr,
    input  logic                  wb_we,
    output cpu_pkg::reg_addr_t    rf_raddr_a,
    output cpu_pkg::reg_addr_t    rf_raddr_b,
    input  logic [DATA_WIDTH-1:0] rf_rdata_a,
    input  logic [DATA_WIDTH-1:0] rf_rdata_b,
    output cpu_pkg::id_ex_t       id_ex_d,
    output logic                  stall_load,
    output logic                  branch_taken,
    output logic [DATA_WIDTH-1:0] branch_target
);

    logic [5:0]            opcode;
    logic [5:0]            funct;
    cpu_pkg::reg_addr_t    rs;
    cpu_pkg::reg_addr_t    rt;
    logic [15:0]           imm;
    logic [DATA_WIDTH-1:0] imm_ext;
    logic [DATA_WIDTH-1:0] fwd_a;
    logic [DATA_WIDTH-1:0] fwd_b;
    cpu_pkg::alu_op_t      alu_op;
    cpu_pkg::wb_sel_t      wb_sel;
    cpu_pkg::reg_addr_t    dest;
    logic                  reg_we;
    logic                  mem_we;
    logic                  mem_rd;
    logic                  use_imm;
    logic                  zero_ext;
    logic                  use_shamt;
    logic                  use_b;
    logic                  is_beq;
    logic                  is_bne;
    logic                  is_j;

    // newest producer first, loads in execute are covered by the stall
    function automatic logic [DATA_WIDTH-1:0] forward(input cpu_pkg::reg_addr_t src,
                                                      input logic [DATA_WIDTH-1:0] rf_val);
        if (src == '0)
            return '0;
        else if (id_ex_q.reg_we && !id_ex_q.mem_rd && id_ex_q.dest == src)
            return ex_result;
        else if (ex_mem_q.reg_we && ex_mem_q.dest == src)
            return ex_mem_q.result;
        else if (wb_we && wb_addr == src)
            return wb_data;
        else
            return rf_val;
    endfunction

    assign opcode     = if_id.instr[31:26];
    assign rs         = if_id.instr[25:21];
    assign rt         = if_id.instr[20:16];
    assign imm        = if_id.instr[15:0];
    assign funct      = if_id.instr[5:0];
    assign rf_raddr_a = rs;
    assign rf_raddr_b = rt;

    always_comb
    begin
        alu_op    = cpu_pkg::alu_add;
        wb_sel    = cpu_pkg::wb_alu;
        dest      = rt;
        reg_we    = 1'b0;
        mem_we    = 1'b0;
        mem_rd    = 1'b0;
        use_imm   = 1'b1;
        zero_ext  = 1'b0;
        use_shamt = 1'b0;
        use_b     = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_j      = 1'b0;
        case (opcode)
            cpu_pkg::op_special:
            begin
                dest    = if_id.instr[15:11];
                reg_we  = 1'b1;
                use_imm = 1'b0;
                use_b   = 1'b1;
                case (funct)
                    cpu_pkg::fn_addu: alu_op = cpu_pkg::alu_add;
                    cpu_pkg::fn_subu: alu_op = cpu_pkg::alu_sub;
                    cpu_pkg::fn_and:  alu_op = cpu_pkg::alu_and;
                    cpu_pkg::fn_or:   alu_op = cpu_pkg::alu_or;
                    cpu_pkg::fn_xor:  alu_op = cpu_pkg::alu_xor;
                    cpu_pkg::fn_slt:  alu_op = cpu_pkg::alu_slt;
                    cpu_pkg::fn_sll:
                    begin
                        alu_op    = cpu_pkg::alu_sll;
                        use_shamt = 1'b1;
                    end
                    default: reg_we = 1'b0;
                endcase
            end
            cpu_pkg::op_addiu: reg_we = 1'b1;
            cpu_pkg::op_andi:
            begin
                alu_op   = cpu_pkg::alu_and;
                zero_ext = 1'b1;
                reg_we   = 1'b1;
            end
            cpu_pkg::op_ori:
            begin
                alu_op   = cpu_pkg::alu_or;
                zero_ext = 1'b1;
                reg_we   = 1'b1;
            end
            cpu_pkg::op_lui:
            begin
                alu_op = cpu_pkg::alu_lui;
                reg_we = 1'b1;
            end
            cpu_pkg::op_lw:
            begin
                reg_we = 1'b1;
                mem_rd = 1'b1;
                wb_sel = cpu_pkg::wb_mem;
            end
            cpu_pkg::op_sw:
            begin
                mem_we = 1'b1;
                use_b  = 1'b1;
            end
            cpu_pkg::op_beq:
            begin
                is_beq = 1'b1;
                use_b  = 1'b1;
            end
            cpu_pkg::op_bne:
            begin
                is_bne = 1'b1;
                use_b  = 1'b1;
            end
            cpu_pkg::op_j: is_j = 1'b1;
            default: ;
        endcase
    end

    assign imm_ext = zero_ext ? {{(DATA_WIDTH-16){1'b0}}, imm} : {{(DATA_WIDTH-16){imm[15]}}, imm};

    always_comb
    begin
        fwd_a = forward(rs, rf_rdata_a);
        fwd_b = forward(rt, rf_rdata_b);
    end

    // load result not ready until its memory stage
    assign stall_load = id_ex_q.mem_rd && id_ex_q.dest != '0 &&
                        ((!is_j && id_ex_q.dest == rs) || (use_b && id_ex_q.dest == rt));

    assign branch_taken = !stall_load &&
                          (is_j || (is_beq && fwd_a == fwd_b) || (is_bne && fwd_a != fwd_b));
    assign branch_target = is_j ? {if_id.npc[DATA_WIDTH-1:28], if_id.instr[25:0], 2'b00}
                                : if_id.npc + {imm_ext[DATA_WIDTH-3:0], 2'b00};

    assign id_ex_d = '{
        op_a:       use_shamt ? {{(DATA_WIDTH-5){1'b0}}, if_id.instr[10:6]} : fwd_a,
        op_b:       use_imm ? imm_ext : fwd_b,
        store_data: fwd_b,
        alu_op:     alu_op,
        dest:       dest,
        reg_we:     reg_we,
        mem_we:     mem_we,
        mem_rd:     mem_rd,
        wb_sel:     wb_sel
    };

endmodule

`default_nettype wire

//--- source/execute_unit.sv
`default_nettype none

module execute_unit #(
    parameter int DATA_WIDTH = cpu_pkg::data_width
) (
    input  cpu_pkg::id_ex_t       id_ex_q,
    output logic [DATA_WIDTH-1:0] ex_result,
    output cpu_pkg::ex_mem_t      ex_mem_d
);

    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    logic                  less;

    assign a    = id_ex_q.op_a;
    assign b    = id_ex_q.op_b;
    assign less = $signed(a) < $signed(b);

    always_comb
    begin
        case (id_ex_q.alu_op)
            cpu_pkg::alu_add: ex_result = a + b;
            cpu_pkg::alu_sub: ex_result = a - b;
            cpu_pkg::alu_and: ex_result = a & b;
            cpu_pkg::alu_or:  ex_result = a | b;
            cpu_pkg::alu_xor: ex_result = a ^ b;
            cpu_pkg::alu_slt: ex_result = {{(DATA_WIDTH-1){1'b0}}, less};
            // shift amount rides in operand a
            cpu_pkg::alu_sll: ex_result = b << a[4:0];
            cpu_pkg::alu_lui: ex_result = {b[15:0], 16'h0000};
            default:          ex_result = a + b;
        endcase
    end

    assign ex_mem_d = '{
        result:     ex_result,
        store_data: id_ex_q.store_data,
        dest:       id_ex_q.dest,
        reg_we:     id_ex_q.reg_we,
        mem_we:     id_ex_q.mem_we,
        mem_rd:     id_ex_q.mem_rd,
        wb_sel:     id_ex_q.wb_sel
    };

endmodule

`default_nettype wire

//--- source/mem_writeback.sv
`default_nettype none

module mem_writeback #(
    parameter int DATA_WIDTH = cpu_pkg::data_width
) (
    input  logic                  halt,
    input  cpu_pkg::ex_mem_t      ex_mem_q,
    input  logic [DATA_WIDTH-1:0] dmem_rdata,
    output logic [DATA_WIDTH-1:0] dmem_addr,
    output logic [DATA_WIDTH-1:0] dmem_wdata,
    output logic                  dmem_wena,
    output cpu_pkg::mem_wb_t      mem_wb_d
);

    logic                  mem_access;
    logic [DATA_WIDTH-1:0] wb_word;

    // address bus stays quiet unless a load or store is in this stage
    assign mem_access = ex_mem_q.mem_rd || ex_mem_q.mem_we;
    assign dmem_addr  = mem_access ? ex_mem_q.result : '0;
    assign dmem_wdata = ex_mem_q.store_data;
    assign dmem_wena  = ex_mem_q.mem_we && !halt;

    always_comb
    begin
        if (ex_mem_q.wb_sel == cpu_pkg::wb_mem)
            wb_word = dmem_rdata;
        else
            wb_word = ex_mem_q.result;
    end

    assign mem_wb_d = '{
        result: wb_word,
        dest:   ex_mem_q.dest,
        reg_we: ex_mem_q.reg_we
    };

endmodule

`default_nettype wire

//--- source/cpu_core.sv
`default_nettype none

module cpu_core #(
    parameter int                    DATA_WIDTH = cpu_pkg::data_width,
    parameter logic [DATA_WIDTH-1:0] RESET_PC   = cpu_pkg::reset_vector
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  halt,
    input  logic [DATA_WIDTH-1:0] imem_data,
    input  logic [DATA_WIDTH-1:0] dmem_rdata,
    output logic [DATA_WIDTH-1:0] imem_addr,
    output logic [DATA_WIDTH-1:0] dmem_addr,
    output logic [DATA_WIDTH-1:0] dmem_wdata,
    output logic                  dmem_wena,
    output logic [DATA_WIDTH-1:0] probe_reg
);

    logic                  stall_load;
    logic                  branch_taken;
    logic [DATA_WIDTH-1:0] branch_target;
    logic [DATA_WIDTH-1:0] pc_plus4;
    logic [DATA_WIDTH-1:0] ex_result;
    logic [DATA_WIDTH-1:0] rf_rdata_a;
    logic [DATA_WIDTH-1:0] rf_rdata_b;
    cpu_pkg::reg_addr_t    rf_raddr_a;
    cpu_pkg::reg_addr_t    rf_raddr_b;
    cpu_pkg::if_id_t       if_id_d;
    cpu_pkg::if_id_t       if_id_q;
    cpu_pkg::id_ex_t       id_ex_d;
    cpu_pkg::id_ex_t       id_ex_q;
    cpu_pkg::ex_mem_t      ex_mem_d;
    cpu_pkg::ex_mem_t      ex_mem_q;
    cpu_pkg::ex_mem_t      ex_mem_fwd;
    cpu_pkg::mem_wb_t      mem_wb_d;
    cpu_pkg::mem_wb_t      mem_wb_q;

    assign if_id_d = '{instr: imem_data, npc: pc_plus4};

    // memory stage as decode sees it, load data in place of the address
    always_comb
    begin
        ex_mem_fwd        = ex_mem_q;
        ex_mem_fwd.result = mem_wb_d.result;
    end

    fetch_unit #(.DATA_WIDTH(DATA_WIDTH), .RESET_PC(RESET_PC)) i_fetch_unit (
        .clk(clk), .rst(rst), .halt(halt), .stall_load(stall_load),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .imem_addr(imem_addr), .pc_plus4(pc_plus4)
    );

    pipe_stage #(.payload_t(cpu_pkg::if_id_t)) i_if_id (
        .clk(clk), .rst(rst), .hold(halt || stall_load), .bubble(branch_taken),
        .d(if_id_d), .q(if_id_q)
    );

    decode_unit #(.DATA_WIDTH(DATA_WIDTH)) i_decode_unit (
        .if_id(if_id_q), .id_ex_q(id_ex_q), .ex_result(ex_result), .ex_mem_q(ex_mem_fwd),
        .wb_data(mem_wb_q.result), .wb_addr(mem_wb_q.dest), .wb_we(mem_wb_q.reg_we),
        .rf_raddr_a(rf_raddr_a), .rf_raddr_b(rf_raddr_b),
        .rf_rdata_a(rf_rdata_a), .rf_rdata_b(rf_rdata_b), .id_ex_d(id_ex_d),
        .stall_load(stall_load), .branch_taken(branch_taken), .branch_target(branch_target)
    );

    reg_file #(.DATA_WIDTH(DATA_WIDTH)) i_reg_file (
        .clk(clk), .rst(rst), .we(mem_wb_q.reg_we), .waddr(mem_wb_q.dest),
        .raddr_a(rf_raddr_a), .raddr_b(rf_raddr_b), .wdata(mem_wb_q.result),
        .rdata_a(rf_rdata_a), .rdata_b(rf_rdata_b), .probe(probe_reg)
    );

    pipe_stage #(.payload_t(cpu_pkg::id_ex_t)) i_id_ex (
        .clk(clk), .rst(rst), .hold(halt), .bubble(stall_load), .d(id_ex_d), .q(id_ex_q)
    );

    execute_unit #(.DATA_WIDTH(DATA_WIDTH)) i_execute_unit (
        .id_ex_q(id_ex_q), .ex_result(ex_result), .ex_mem_d(ex_mem_d)
    );

    pipe_stage #(.payload_t(cpu_pkg::ex_mem_t)) i_ex_mem (
        .clk(clk), .rst(rst), .hold(halt), .bubble(1'b0), .d(ex_mem_d), .q(ex_mem_q)
    );

    mem_writeback #(.DATA_WIDTH(DATA_WIDTH)) i_mem_writeback (
        .halt(halt), .ex_mem_q(ex_mem_q), .dmem_rdata(dmem_rdata),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_wena(dmem_wena),
        .mem_wb_d(mem_wb_d)
    );

    pipe_stage #(.payload_t(cpu_pkg::mem_wb_t)) i_mem_wb (
        .clk(clk), .rst(rst), .hold(halt), .bubble(1'b0), .d(mem_wb_d), .q(mem_wb_q)
    );

endmodule

`default_nettype wire

//--- verification/cpu_core_assertions.sv
`default_nettype none

module cpu_core_assertions (
    input logic            clk,
    input logic            rst,
    input logic            halt,
    input logic            dmem_wena,
    input logic [31:0]     imem_addr,
    input logic            branch_taken,
    input cpu_pkg::if_id_t if_id_q
);

    timeunit 1ns;
    timeprecision 1ps;

    // no data write while frozen or in reset
    wena_quiet: assert property (@(posedge clk) (halt || rst) |-> !dmem_wena)
        else $error("data write enable high during halt or reset");

    // the pc holds while halted
    pc_frozen: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(imem_addr))
        else $error("instruction address moved during halt");

    // the word fetched behind a taken branch is replaced by a bubble
    squash_store: assert property (@(posedge clk) disable iff (rst)
        (branch_taken && !halt) |=> if_id_q.instr[31:26] != cpu_pkg::op_sw)
        else $error("store survived behind a taken branch");

endmodule

`default_nettype wire

//--- verification/cpu_core_tb.sv
`default_nettype none

module cpu_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_tests      = 6;
    localparam int cycle_budget = 40;
    localparam int halt_len     = 5;
    localparam int watchdog_ns  = n_tests * (cycle_budget + 6) * 20 + 2000;

    logic        clk = 1'b0;
    logic        rst;
    logic        halt;
    logic [31:0] imem_data;
    logic [31:0] dmem_rdata;
    logic [31:0] imem_addr;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_wena;
    logic [31:0] probe_reg;

    logic [31:0] imem [16];
    logic [31:0] dmem [64];
    logic [31:0] imem_off;
    logic [31:0] stores [$];
    logic [31:0] store_addrs [$];
    logic [31:0] rng = 32'hda4f_7653;

    // test table
    string       test_name [n_tests];
    logic [31:0] prog [n_tests][16];
    logic [31:0] exp_store [n_tests][8];
    logic [31:0] exp_addr [n_tests][8];
    int          exp_count [n_tests];
    logic [31:0] exp_probe [n_tests];
    int          halt_at [n_tests];

    int errors = 0;
    int passed = 0;

    always #10 clk = ~clk;

    cpu_core i_cpu_core (
        .clk(clk), .rst(rst), .halt(halt), .imem_data(imem_data), .dmem_rdata(dmem_rdata),
        .imem_addr(imem_addr), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_wena(dmem_wena), .probe_reg(probe_reg)
    );

    bind cpu_core cpu_core_assertions i_cpu_core_assertions (
        .clk(clk), .rst(rst), .halt(halt), .dmem_wena(dmem_wena), .imem_addr(imem_addr),
        .branch_taken(branch_taken), .if_id_q(if_id_q)
    );

    // nop beyond the program
    assign imem_off   = imem_addr - cpu_pkg::reset_vector;
    assign imem_data  = (imem_off < 32'd64) ? imem[imem_off[5:2]] : 32'h0;
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk)
    begin
        if (dmem_wena)
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        if (!rst && dmem_wena)
        begin
            stores.push_back(dmem_wdata);
            store_addrs.push_back(dmem_addr);
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] encode_r(input logic [5:0] fn, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [4:0] rd,
                                             input logic [4:0] sh);
        return {cpu_pkg::op_special, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // jump to a word index of the program
    function automatic logic [31:0] encode_j(input int idx);
        logic [31:0] addr;
        addr = cpu_pkg::reset_vector + 32'(idx * 4);
        return {cpu_pkg::op_j, addr[27:2]};
    endfunction

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] s;
        logic [31:0] d;
        logic [31:0] an;
        logic [31:0] o;
        logic [31:0] x;
        logic [31:0] lt;
        logic [31:0] sh;
        logic [15:0] i1;
        logic [15:0] i2;
        logic [15:0] i3;
        logic [15:0] i4;
        logic [31:0] e1;
        logic [31:0] e2;
        for (int t = 0; t < n_tests; t++)
        begin
            for (int k = 0; k < 16; k++)
                prog[t][k] = 32'h0;
            exp_count[t] = 0;
            exp_probe[t] = 32'h0;
            halt_at[t]   = -1;
        end

        // dependent register ops back to back
        a  = 32'h0000_1234;
        b  = 32'h0000_0f0f;
        s  = a + b;
        d  = s - a;
        an = d & s;
        o  = an | a;
        x  = o ^ s;
        lt = ($signed(d) < $signed(s)) ? 32'd1 : 32'd0;
        sh = x << 3;
        test_name[0] = "alu_chain";
        prog[0][0] = encode_i(cpu_pkg::op_ori, 5'd0, 5'd1, a[15:0]);
        prog[0][1] = encode_i(cpu_pkg::op_ori, 5'd0, 5'd2, b[15:0]);
        prog[0][2] = encode_r(cpu_pkg::fn_addu, 5'd1, 5'd2, 5'd3, 5'd0);
        prog[0][3] = encode_r(cpu_pkg::fn_subu, 5'd3, 5'd1, 5'd4, 5'd0);
        prog[0][4] = encode_r(cpu_pkg::fn_and, 5'd4, 5'd3, 5'd5, 5'd0);
        prog[0][5] = encode_r(cpu_pkg::fn_or, 5'd5, 5'd1, 5'd6, 5'd0);
        prog[0][6] = encode_r(cpu_pkg::fn_xor, 5'd6, 5'd3, 5'd7, 5'd0);
        prog[0][7] = encode_r(cpu_pkg::fn_slt, 5'd4, 5'd3, 5'd8, 5'd0);
        prog[0][8] = encode_r(cpu_pkg::fn_sll, 5'd0, 5'd7, 5'd9, 5'd3);
        for (int k = 0; k < 7; k++)
        begin
            prog[0][9+k]   = encode_i(cpu_pkg::op_sw, 5'd0, 5'(3 + k), 16'(4 * k));
            exp_addr[0][k] = 32'(4 * k);
        end
        exp_store[0][0] = s;
        exp_store[0][1] = d;
        exp_store[0][2] = an;
        exp_store[0][3] = o;
        exp_store[0][4] = x;
        exp_store[0][5] = lt;
        exp_store[0][6] = sh;
        exp_count[0] = 7;

        // immediates, sign extended for addiu and zero extended for logic ops
        rng = lcg_next(rng);
        i1  = rng[31:16];
        rng = lcg_next(rng);
        i2  = rng[31:16];
        rng = lcg_next(rng);
        i3  = rng[31:16];
        rng = lcg_next(rng);
        i4  = rng[31:16];
        e1  = {{16{i1[15]}}, i1};
        e2  = e1 & {16'h0, i2};
        test_name[1] = "imm_ops";
        prog[1][0] = encode_i(cpu_pkg::op_addiu, 5'd0, 5'd1, i1);
        prog[1][1] = encode_i(cpu_pkg::op_andi, 5'd1, 5'd2, i2);
        prog[1][2] = encode_i(cpu_pkg::op_ori, 5'd2, 5'd3, i3);
        prog[1][3] = encode_i(cpu_pkg::op_lui, 5'd0, 5'd4, i4);
        for (int k = 0; k < 4; k++)
        begin
            prog[1][4+k]   = encode_i(cpu_pkg::op_sw, 5'd0, 5'(1 + k), 16'(4 * k));
            exp_addr[1][k] = 32'(4 * k);
        end
        exp_store[1][0] = e1;
        exp_store[1][1] = e2;
        exp_store[1][2] = e2 | {16'h0, i3};
        exp_store[1][3] = {i4, 16'h0};
        exp_count[1] = 4;

        test_name[2] = "load_use";
        prog[2][0] = encode_i(cpu_pkg::op_ori, 5'd0, 5'd1, 16'h5a5a);
        prog[2][1] = encode_i(cpu_pkg::op_sw, 5'd0, 5'd1, 16'd16);
        prog[2][2] = encode_i(cpu_pkg::op_lw, 5'd0, 5'd2, 16'd16);
        prog[2][3] = encode_r(cpu_pkg::fn_addu, 5'd2, 5'd1, 5'd3, 5'd0);
        prog[2][4] = encode_i(cpu_pkg::op_sw, 5'd0, 5'd3, 16'd20);
        prog[2][5] = encode_i(cpu_pkg::op_lw, 5'd0, 5'd4, 16'd16);
        prog[2][6] = encode_i(cpu_pkg::op_sw, 5'd0, 5'd4, 16'd24);
        exp_store[2][0] = 32'h0000_5a5a;
        exp_store[2][1] = 32'h0000_5a5a + 32'h0000_5a5a;
        exp_store[2][2] = 32'h0000_5a5a;
        exp_addr[2][0]  = 32'd16;
        exp_addr[2][1]  = 32'd20;
        exp_addr[2][2]  = 32'd24;
        exp_count[2] = 3;

        // squashed words store 0xbad and must never show up
        test_name[3] = "branches";
        prog[3][0]  = encode_i(cpu_pkg::op_ori, 5'd0, 5'd1, 16'd7);
        prog[3][1]  = encode_i(cpu_pkg::op_ori, 5'd0, 5'd3, 16'h0bad);
        prog[3][2]  = encode_i(cpu_pkg::op_beq, 5'd1, 5'd1, 16'd1);
        prog[3][3]  = encode_i(cpu_pkg::op_sw, 5'd0, 5'd3, 16'd0);
        prog[3][4]  = encode_i(cpu_pkg::op_bne, 5'd1, 5'd0, 16'd1);
        prog[3][5]  = encode_i(cpu_pkg::op_sw, 5'd0, 5'd3, 16'd4);
        prog[3][6]  = encode_i(cpu_pkg::op_beq, 5'd1, 5'd0, 16'd1);
        prog[3][7]  = encode_i(cpu_pkg::op_sw, 5'd0, 5'd1, 16'd8);
        prog[3][8]  = encode_i(cpu_pkg::op_bne, 5'd1, 5'd1, 16'd1);
        prog[3][9]  = encode_i(cpu_pkg::op_ori, 5'd0, 5'd4, 16'h0042);
        prog[3][10] = encode_i(cpu_pkg::op_sw, 5'd0, 5'd4, 16'd12);
        prog[3][11] = encode_j(13);
        prog[3][12] = encode_i(cpu_pkg::op_sw, 5'd0, 5'd3, 16'd16);
        prog[3][13] = encode_i(cpu_pkg::op_sw, 5'd0, 5'd1, 16'd20);
        exp_store[3][0] = 32'd7;
        exp_store[3][1] = 32'h0000_0042;
        exp_store[3][2] = 32'd7;
        exp_addr[3][0]  = 32'd8;
        exp_addr[3][1]  = 32'd12;
        exp_addr[3][2]  = 32'd20;
        exp_count[3] = 3;

        // same program as alu_chain, frozen while its stores drain
        test_name[4] = "halt_resume";
        prog[4]      = prog[0];
        exp_store[4] = exp_store[0];
        exp_addr[4]  = exp_addr[0];
        exp_count[4] = exp_count[0];
        halt_at[4]   = 11;

        rng = lcg_next(rng);
        i1  = rng[31:16];
        test_name[5] = "probe_r28";
        prog[5][0] = encode_i(cpu_pkg::op_ori, 5'd0, 5'd28, i1);
        prog[5][1] = encode_r(cpu_pkg::fn_addu, 5'd28, 5'd28, 5'd28, 5'd0);
        prog[5][2] = encode_r(cpu_pkg::fn_sll, 5'd0, 5'd28, 5'd28, 5'd2);
        prog[5][3] = encode_i(cpu_pkg::op_ori, 5'd0, 5'd27, 16'h00ff);
        exp_probe[5] = ({16'h0, i1} + {16'h0, i1}) << 2;
    endtask

    task automatic run_test(input int t);
        int          fails;
        logic [31:0] held_addr;
        int          held_stores;
        fails       = 0;
        held_addr   = 32'h0;
        held_stores = 0;
        @(negedge clk);
        rst  = 1'b1;
        halt = 1'b0;
        imem = prog[t];
        for (int k = 0; k < 64; k++)
            dmem[k] = 32'h0;
        stores.delete();
        store_addrs.delete();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        for (int cyc = 0; cyc < cycle_budget; cyc++)
        begin
            @(negedge clk);
            if (cyc == halt_at[t])
            begin
                halt        = 1'b1;
                held_addr   = imem_addr;
                held_stores = stores.size();
            end
            if (halt_at[t] >= 0 && cyc == halt_at[t] + halt_len)
            begin
                if (imem_addr != held_addr)
                begin
                    $display("FAIL %s: imem_addr expected %h actual %h", test_name[t],
                             held_addr, imem_addr);
                    fails++;
                end
                if (stores.size() != held_stores)
                begin
                    $display("FAIL %s: stores during halt expected %0d actual %0d",
                             test_name[t], held_stores, stores.size());
                    fails++;
                end
                halt = 1'b0;
            end
        end
        if (stores.size() != exp_count[t])
        begin
            $display("FAIL %s: store count expected %0d actual %0d", test_name[t],
                     exp_count[t], stores.size());
            fails++;
        end
        for (int k = 0; k < exp_count[t] && k < stores.size(); k++)
        begin
            if (store_addrs[k] != exp_addr[t][k])
            begin
                $display("FAIL %s: store %0d address expected %h actual %h", test_name[t], k,
                         exp_addr[t][k], store_addrs[k]);
                fails++;
            end
            if (stores[k] != exp_store[t][k])
            begin
                $display("FAIL %s: store %0d expected %h actual %h", test_name[t], k,
                         exp_store[t][k], stores[k]);
                fails++;
            end
        end
        if (probe_reg != exp_probe[t])
        begin
            $display("FAIL %s: probe expected %h actual %h", test_name[t], exp_probe[t],
                     probe_reg);
            fails++;
        end
        if (fails == 0)
        begin
            $display("PASS %s", test_name[t]);
            passed++;
        end
        else
        begin
            $display("test %s finished with %0d mismatches", test_name[t], fails);
        end
        errors += fails;
    endtask

    initial
    begin
        #(watchdog_ns);
        $display("watchdog expired before all tests finished");
        $display("Done: errors found");
        $finish;
    end

    initial
    begin
        rst  = 1'b1;
        halt = 1'b0;
        for (int k = 0; k < 16; k++)
            imem[k] = 32'h0;
        for (int k = 0; k < 64; k++)
            dmem[k] = 32'h0;
        build_table();
        for (int t = 0; t < n_tests; t++)
            run_test(t);
        $display("tests %0d, passed %0d, failed %0d, mismatches %0d", n_tests, passed,
                 n_tests - passed, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
source/cpu_pkg.sv
source/fetch_unit.sv
source/pipe_stage.sv
source/reg_file.sv
source/decode_unit.sv
source/execute_unit.sv
source/mem_writeback.sv
source/cpu_core.sv
verification/cpu_core_assertions.sv
verification/cpu_core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench, result taken from the log
verilator --binary --timing --assert -f flist.f --top-module cpu_core_tb -o sim_cpu \
    && ./obj_dir/sim_cpu > sim.log 2>&1 \
    && cat sim.log \
    || { cat sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
grep -q "Done: errors found" sim.log && exit 1 || exit 0
